// File: sim.f
+incdir+hdl
hdl/soc_pkg.sv
hdl/mem_decoder.sv
hdl/tcm_dp.sv
hdl/clint.sv
hdl/soc_fabric.sv
tests/tb_soc_fabric.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the fabric testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -f sim.f --top-module tb_soc_fabric \
    -Mdir "$BUILD_DIR" -o tb_soc_fabric
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/tb_soc_fabric" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

# The log decides the result
if grep -q "Checks failed" "$LOG"; then
    echo "Simulation failed"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi
echo "Simulation passed"
exit 0

// File: tests/tb_soc_fabric.sv
`timescale 1ns/10ps
`include "soc_consts.svh"

module tb_soc_fabric;

    localparam int CLK_PERIOD = 4;
    localparam int NUM_TESTS  = 6;
    // 200 cycles per test, plus reset and margin
    localparam int WATCHDOG_NS = (NUM_TESTS * 200 + 100) * CLK_PERIOD;
    localparam logic [31:0] LCG_SEED = 32'h663f_d8c6;
    localparam soc_pkg::addr_t CLINT_BASE = 32'hF000_0000;

    logic clk_i;
    logic reset_i;
    logic i_strobe_i;
    soc_pkg::addr_t i_addr_i;
    logic i_ready_o;
    soc_pkg::word_t i_code_o;
    logic d_strobe_i;
    soc_pkg::addr_t d_addr_i;
    logic d_rw_i;
    soc_pkg::byte_en_t d_byte_enable_i;
    soc_pkg::word_t d_wdata_i;
    logic d_ready_o;
    soc_pkg::word_t d_rdata_o;
    logic dev_strobe_o;
    soc_pkg::addr_t dev_addr_o;
    logic dev_rw_o;
    soc_pkg::byte_en_t dev_byte_enable_o;
    soc_pkg::word_t dev_wdata_o;
    logic dev_ready_i;
    soc_pkg::word_t dev_rdata_i;
    logic tmr_irq_o;
    logic sft_irq_o;

    // Device port as seen in the strobe cycle of the last data access
    logic dev_seen;
    soc_pkg::addr_t dev_addr_seen;
    logic dev_rw_seen;
    soc_pkg::byte_en_t dev_be_seen;
    soc_pkg::word_t dev_wdata_seen;

    logic [31:0] lcg_state;
    int dev_delay;

    soc_fabric uut (.*);

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // --------------------
    // Helpers
    // --------------------
    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Word the device model answers for an address
    function automatic soc_pkg::word_t device_word(input soc_pkg::addr_t addr);
        return {addr[15:0] ^ 16'h5a5a, ~addr[15:0]};
    endfunction

    // Old word with the enabled byte lanes replaced
    function automatic soc_pkg::word_t merge_bytes(input soc_pkg::word_t old_word,
                                                   input soc_pkg::word_t new_word,
                                                   input soc_pkg::byte_en_t be);
        soc_pkg::word_t result;
        result = old_word;
        for (int k = 0; k < 4; k++) begin
            if (be[k]) begin
                result[8*k +: 8] = new_word[8*k +: 8];
            end
        end
        return result;
    endfunction

    function automatic soc_pkg::addr_t clint_addr(input soc_pkg::clint_index_t idx);
        return CLINT_BASE + {27'b0, idx, 2'b00};
    endfunction

    task automatic check_eq(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s got 0x%08h, expected 0x%08h",
                     $time, name, actual, expected);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    // One data request, latency counted in cycles after the strobe
    task automatic data_access(input soc_pkg::addr_t addr, input logic rw,
                               input soc_pkg::byte_en_t be, input soc_pkg::word_t wdata,
                               output soc_pkg::word_t rdata, output int latency);
        logic ready_seen;
        @(negedge clk_i);
        d_strobe_i      = 1'b1;
        d_addr_i        = addr;
        d_rw_i          = rw;
        d_byte_enable_i = be;
        d_wdata_i       = wdata;
        // Outputs sampled just after the rising edge, clear of register updates
        @(posedge clk_i);
        #1;
        // Device fields are combinational in the strobe cycle
        dev_seen       = dev_strobe_o;
        dev_addr_seen  = dev_addr_o;
        dev_rw_seen    = dev_rw_o;
        dev_be_seen    = dev_byte_enable_o;
        dev_wdata_seen = dev_wdata_o;
        latency    = 1;
        ready_seen = d_ready_o;
        rdata      = d_rdata_o;
        @(negedge clk_i);
        d_strobe_i      = 1'b0;
        d_rw_i          = 1'b0;
        d_byte_enable_i = '0;
        d_wdata_i       = '0;
        while (!ready_seen) begin
            @(posedge clk_i);
            #1;
            latency++;
            ready_seen = d_ready_o;
            rdata      = d_rdata_o;
        end
    endtask

    task automatic fetch(input soc_pkg::addr_t addr, output soc_pkg::word_t code,
                         output int latency);
        logic ready_seen;
        @(negedge clk_i);
        i_strobe_i = 1'b1;
        i_addr_i   = addr;
        @(posedge clk_i);
        #1;
        latency    = 1;
        ready_seen = i_ready_o;
        code       = i_code_o;
        @(negedge clk_i);
        i_strobe_i = 1'b0;
        while (!ready_seen) begin
            @(posedge clk_i);
            #1;
            latency++;
            ready_seen = i_ready_o;
            code       = i_code_o;
        end
    endtask

    // --------------------
    // Directed tests
    // --------------------
    task automatic test_reset_state();
        check_eq("i_ready_o", 32'(i_ready_o), 0);
        check_eq("d_ready_o", 32'(d_ready_o), 0);
        check_eq("dev_strobe_o", 32'(dev_strobe_o), 0);
        check_eq("tmr_irq_o", 32'(tmr_irq_o), 0);
        check_eq("sft_irq_o", 32'(sft_irq_o), 0);
    endtask

    task automatic test_tcm();
        soc_pkg::word_t rdata;
        soc_pkg::word_t expected;
        int latency;
        data_access(32'h0000_0100, 1'b1, 4'hF, 32'hdead_beef, rdata, latency);
        check_eq("d_ready_o latency", latency, 1);
        check_eq("dev_strobe_o", 32'(dev_seen), 0);
        data_access(32'h0000_0104, 1'b1, 4'hF, 32'h1234_5678, rdata, latency);
        // Partial write touches lanes 0 and 2
        expected = merge_bytes(32'h1234_5678, 32'haabb_ccdd, 4'b0101);
        data_access(32'h0000_0104, 1'b1, 4'b0101, 32'haabb_ccdd, rdata, latency);
        check_eq("d_ready_o latency", latency, 1);
        data_access(32'h0000_0100, 1'b0, 4'hF, '0, rdata, latency);
        check_eq("d_rdata_o", rdata, 32'hdead_beef);
        check_eq("d_ready_o latency", latency, 1);
        check_eq("dev_strobe_o", 32'(dev_seen), 0);
        data_access(32'h0000_0104, 1'b0, 4'hF, '0, rdata, latency);
        check_eq("d_rdata_o", rdata, expected);
        // Same words through the instruction port
        fetch(32'h0000_0104, rdata, latency);
        check_eq("i_code_o", rdata, expected);
        check_eq("i_ready_o latency", latency, 1);
        fetch(32'h0000_0100, rdata, latency);
        check_eq("i_code_o", rdata, 32'hdead_beef);
    endtask

    task automatic test_device();
        soc_pkg::word_t rdata;
        soc_pkg::addr_t addr;
        int latency;
        data_access(32'hC000_0010, 1'b1, 4'b0011, 32'hcafe_f00d, rdata, latency);
        check_eq("dev_strobe_o", 32'(dev_seen), 1);
        check_eq("dev_addr_o", dev_addr_seen, 32'hC000_0010);
        check_eq("dev_rw_o", 32'(dev_rw_seen), 1);
        check_eq("dev_byte_enable_o", 32'(dev_be_seen), 32'h3);
        check_eq("dev_wdata_o", dev_wdata_seen, 32'hcafe_f00d);
        // Responder raises dev_ready_i dev_delay falling edges after the strobe edge
        check_eq("d_ready_o latency", latency, dev_delay + 1);
        // Reads over several random device delays
        for (int k = 0; k < 5; k++) begin
            addr = 32'hC000_0100 + 4 * k;
            data_access(addr, 1'b0, 4'hF, '0, rdata, latency);
            check_eq("dev_strobe_o", 32'(dev_seen), 1);
            check_eq("dev_addr_o", dev_addr_seen, addr);
            check_eq("dev_rw_o", 32'(dev_rw_seen), 0);
            check_eq("d_rdata_o", rdata, device_word(addr));
            check_eq("d_ready_o latency", latency, dev_delay + 1);
        end
    endtask

    task automatic test_software_irq();
        soc_pkg::word_t rdata;
        int latency;
        data_access(clint_addr(`SOC_CLINT_MSIP), 1'b1, 4'hF, 32'd1, rdata, latency);
        check_eq("d_ready_o latency", latency, 1);
        check_eq("sft_irq_o", 32'(sft_irq_o), 1);
        data_access(clint_addr(`SOC_CLINT_MSIP), 1'b0, 4'hF, '0, rdata, latency);
        check_eq("msip", rdata, 1);
        data_access(clint_addr(`SOC_CLINT_MSIP), 1'b1, 4'hF, 32'd0, rdata, latency);
        check_eq("sft_irq_o", 32'(sft_irq_o), 0);
    endtask

    task automatic test_timer();
        soc_pkg::word_t mtime_first;
        soc_pkg::word_t mtime_second;
        soc_pkg::word_t rdata;
        time t_first;
        time t_second;
        int latency;
        int elapsed;
        int waited;
        data_access(clint_addr(`SOC_CLINT_MTIME_LO), 1'b0, 4'hF, '0, mtime_first, latency);
        t_first = $time;
        repeat (37) @(posedge clk_i);
        data_access(clint_addr(`SOC_CLINT_MTIME_LO), 1'b0, 4'hF, '0, mtime_second, latency);
        t_second = $time;
        elapsed  = int'((t_second - t_first) / CLK_PERIOD);
        check_eq("mtime increase at least elapsed/div",
                 32'(mtime_second - mtime_first >= elapsed / `SOC_CLINT_TICK_DIV), 1);
        // Compare 5 ticks ahead of now
        data_access(clint_addr(`SOC_CLINT_MTIME_LO), 1'b0, 4'hF, '0, rdata, latency);
        data_access(clint_addr(`SOC_CLINT_MTIMECMP_LO), 1'b1, 4'hF, rdata + 5, rdata, latency);
        data_access(clint_addr(`SOC_CLINT_MTIMECMP_HI), 1'b1, 4'hF, '0, rdata, latency);
        check_eq("tmr_irq_o", 32'(tmr_irq_o), 0);
        waited = 0;
        while (!tmr_irq_o && waited < 5 * `SOC_CLINT_TICK_DIV + 10) begin
            @(negedge clk_i);
            waited++;
        end
        check_eq("tmr_irq_o", 32'(tmr_irq_o), 1);
        data_access(clint_addr(`SOC_CLINT_MTIMECMP_HI), 1'b1, 4'hF, '1, rdata, latency);
        data_access(clint_addr(`SOC_CLINT_MTIMECMP_LO), 1'b1, 4'hF, '1, rdata, latency);
        check_eq("tmr_irq_o", 32'(tmr_irq_o), 0);
    endtask

    task automatic test_unmapped();
        soc_pkg::word_t rdata;
        int latency;
        // DRAM segment, write is dropped
        data_access(32'h8000_0040, 1'b1, 4'hF, 32'h5555_aaaa, rdata, latency);
        check_eq("d_ready_o latency", latency, 1);
        data_access(32'h8000_0040, 1'b0, 4'hF, '0, rdata, latency);
        check_eq("d_rdata_o", rdata, 0);
        check_eq("d_ready_o latency", latency, 1);
        check_eq("dev_strobe_o", 32'(dev_seen), 0);
        fetch(32'h8000_0000, rdata, latency);
        check_eq("i_code_o", rdata, 0);
        check_eq("i_ready_o latency", latency, 1);
    endtask

    // --------------------
    // Device model
    // --------------------
    initial begin : device_responder
        forever begin
            @(posedge clk_i);
            if (dev_strobe_o) begin
                lcg_state = lcg_next(lcg_state);
                dev_delay = 1 + int'(lcg_state[20:16]) % 5;
                repeat (dev_delay) @(negedge clk_i);
                dev_rdata_i = device_word(dev_addr_seen);
                dev_ready_i = 1'b1;
                @(negedge clk_i);
                dev_ready_i = 1'b0;
                dev_rdata_i = '0;
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests finished");
        $display("Checks failed");
        $fatal(1);
    end

    initial begin : main_sequence
        clk_i           = 1'b0;
        reset_i         = 1'b1;
        i_strobe_i      = 1'b0;
        i_addr_i        = '0;
        d_strobe_i      = 1'b0;
        d_addr_i        = '0;
        d_rw_i          = 1'b0;
        d_byte_enable_i = '0;
        d_wdata_i       = '0;
        dev_ready_i     = 1'b0;
        dev_rdata_i     = '0;
        lcg_state       = LCG_SEED;
        dev_delay       = 0;
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        reset_i = 1'b0;
        test_reset_state();
        test_tcm();
        test_device();
        test_software_irq();
        test_timer();
        test_unmapped();
        $display("All checks passed");
        $finish;
    end

endmodule

// File: hdl/soc_fabric.sv
`timescale 1ns/10ps

module soc_fabric (
    input  logic                clk_i,
    input  logic                reset_i,
    // Instruction port
    input  logic                i_strobe_i,
    input  soc_pkg::addr_t      i_addr_i,
    output logic                i_ready_o,
    output soc_pkg::word_t      i_code_o,
    // Data port
    input  logic                d_strobe_i,
    input  soc_pkg::addr_t      d_addr_i,
    input  logic                d_rw_i,
    input  soc_pkg::byte_en_t   d_byte_enable_i,
    input  soc_pkg::word_t      d_wdata_i,
    output logic                d_ready_o,
    output soc_pkg::word_t      d_rdata_o,
    // Device port
    output logic                dev_strobe_o,
    output soc_pkg::addr_t      dev_addr_o,
    output logic                dev_rw_o,
    output soc_pkg::byte_en_t   dev_byte_enable_o,
    output soc_pkg::word_t      dev_wdata_o,
    input  logic                dev_ready_i,
    input  soc_pkg::word_t      dev_rdata_i,
    // Interrupts
    output logic                tmr_irq_o,
    output logic                sft_irq_o
);

    // --------------------
    // Decoder to TCM
    // --------------------
    logic                   tcm_i_en;
    soc_pkg::tcm_index_t    tcm_i_index;
    logic                   tcm_d_en;
    logic                   tcm_d_we;
    soc_pkg::tcm_index_t    tcm_d_index;
    soc_pkg::byte_en_t      tcm_byte_enable;
    soc_pkg::word_t         tcm_wdata;
    logic                   tcm_i_ready;
    soc_pkg::word_t         tcm_i_data;
    logic                   tcm_d_ready;
    soc_pkg::word_t         tcm_d_data;

    // Decoder to CLINT
    logic                   clint_en;
    logic                   clint_we;
    soc_pkg::clint_index_t  clint_index;
    soc_pkg::word_t         clint_wdata;
    logic                   clint_ready;
    soc_pkg::word_t         clint_rdata;

    // Address routing and response mux
    mem_decoder u_decoder (
        .clk_i             (clk_i),
        .reset_i           (reset_i),
        .i_strobe_i        (i_strobe_i),
        .i_addr_i          (i_addr_i),
        .i_ready_o         (i_ready_o),
        .i_code_o          (i_code_o),
        .d_strobe_i        (d_strobe_i),
        .d_addr_i          (d_addr_i),
        .d_rw_i            (d_rw_i),
        .d_byte_enable_i   (d_byte_enable_i),
        .d_wdata_i         (d_wdata_i),
        .d_ready_o         (d_ready_o),
        .d_rdata_o         (d_rdata_o),
        .dev_strobe_o      (dev_strobe_o),
        .dev_addr_o        (dev_addr_o),
        .dev_rw_o          (dev_rw_o),
        .dev_byte_enable_o (dev_byte_enable_o),
        .dev_wdata_o       (dev_wdata_o),
        .dev_ready_i       (dev_ready_i),
        .dev_rdata_i       (dev_rdata_i),
        .tcm_i_en_o        (tcm_i_en),
        .tcm_i_index_o     (tcm_i_index),
        .tcm_d_en_o        (tcm_d_en),
        .tcm_d_we_o        (tcm_d_we),
        .tcm_d_index_o     (tcm_d_index),
        .tcm_byte_enable_o (tcm_byte_enable),
        .tcm_wdata_o       (tcm_wdata),
        .tcm_i_ready_i     (tcm_i_ready),
        .tcm_i_data_i      (tcm_i_data),
        .tcm_d_ready_i     (tcm_d_ready),
        .tcm_d_data_i      (tcm_d_data),
        .clint_en_o        (clint_en),
        .clint_we_o        (clint_we),
        .clint_index_o     (clint_index),
        .clint_wdata_o     (clint_wdata),
        .clint_ready_i     (clint_ready),
        .clint_rdata_i     (clint_rdata)
    );

    // Port A fetches code, port B serves data
    tcm_dp u_tcm (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .a_en_i          (tcm_i_en),
        .a_index_i       (tcm_i_index),
        .a_data_o        (tcm_i_data),
        .a_ready_o       (tcm_i_ready),
        .b_en_i          (tcm_d_en),
        .b_we_i          (tcm_d_we),
        .b_index_i       (tcm_d_index),
        .b_byte_enable_i (tcm_byte_enable),
        .b_wdata_i       (tcm_wdata),
        .b_data_o        (tcm_d_data),
        .b_ready_o       (tcm_d_ready)
    );

    // Timer and software interrupt
    clint u_clint (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .en_i      (clint_en),
        .we_i      (clint_we),
        .index_i   (clint_index),
        .wdata_i   (clint_wdata),
        .rdata_o   (clint_rdata),
        .ready_o   (clint_ready),
        .tmr_irq_o (tmr_irq_o),
        .sft_irq_o (sft_irq_o)
    );

endmodule

// File: hdl/clint.sv
`timescale 1ns/10ps
`include "soc_consts.svh"

module clint (
    input  logic                    clk_i,
    input  logic                    reset_i,
    // Register access from the data port
    input  logic                    en_i,
    input  logic                    we_i,
    input  soc_pkg::clint_index_t   index_i,
    input  soc_pkg::word_t          wdata_i,
    output soc_pkg::word_t          rdata_o,
    output logic                    ready_o,
    // Interrupts to the core
    output logic                    tmr_irq_o,
    output logic                    sft_irq_o
);

    localparam int TICK_WIDTH = $clog2(`SOC_CLINT_TICK_DIV);

    logic [TICK_WIDTH-1:0] tick_cnt;
    logic                  tick;
    logic                  wr;
    logic [63:0]           mtime;
    logic [63:0]           mtimecmp;
    logic                  msip;
    soc_pkg::word_t        read_word;

    assign wr = en_i && we_i;

    // --------------------
    // Tick prescaler
    // --------------------
    assign tick = (tick_cnt == TICK_WIDTH'(`SOC_CLINT_TICK_DIV - 1));

    always_ff @(posedge clk_i) begin
        if (reset_i || tick) begin
            tick_cnt <= '0;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    // --------------------
    // Timer registers
    // --------------------
    // Software write wins over the tick
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            mtime <= '0;
        end else if (wr && index_i == `SOC_CLINT_MTIME_LO) begin
            mtime[31:0] <= wdata_i;
        end else if (wr && index_i == `SOC_CLINT_MTIME_HI) begin
            mtime[63:32] <= wdata_i;
        end else if (tick) begin
            mtime <= mtime + 64'd1;
        end
    end

    // Compare starts at all ones so the timer stays quiet
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            mtimecmp <= '1;
            msip     <= 1'b0;
        end else if (wr) begin
            case (index_i)
                `SOC_CLINT_MSIP:        msip           <= wdata_i[0];
                `SOC_CLINT_MTIMECMP_LO: mtimecmp[31:0]  <= wdata_i;
                `SOC_CLINT_MTIMECMP_HI: mtimecmp[63:32] <= wdata_i;
                default: ;
            endcase
        end
    end

    // --------------------
    // Read path
    // --------------------
    always_comb begin
        case (index_i)
            `SOC_CLINT_MSIP:        read_word = {31'b0, msip};
            `SOC_CLINT_MTIMECMP_LO: read_word = mtimecmp[31:0];
            `SOC_CLINT_MTIMECMP_HI: read_word = mtimecmp[63:32];
            `SOC_CLINT_MTIME_LO:    read_word = mtime[31:0];
            `SOC_CLINT_MTIME_HI:    read_word = mtime[63:32];
            default:                read_word = '0;
        endcase
    end

    // Data and ready land one cycle after the enable
    always_ff @(posedge clk_i) begin
        if (en_i) begin
            rdata_o <= read_word;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ready_o <= 1'b0;
        end else begin
            ready_o <= en_i;
        end
    end

    // Level interrupts
    assign tmr_irq_o = (mtime >= mtimecmp);
    assign sft_irq_o = msip;

endmodule

// File: hdl/tcm_dp.sv
`timescale 1ns/10ps
`include "soc_consts.svh"

module tcm_dp (
    input  logic                  clk_i,
    input  logic                  reset_i,
    // Port A, instruction fetch, read only
    input  logic                  a_en_i,
    input  soc_pkg::tcm_index_t   a_index_i,
    output soc_pkg::word_t        a_data_o,
    output logic                  a_ready_o,
    // Port B, data read and byte write
    input  logic                  b_en_i,
    input  logic                  b_we_i,
    input  soc_pkg::tcm_index_t   b_index_i,
    input  soc_pkg::byte_en_t     b_byte_enable_i,
    input  soc_pkg::word_t        b_wdata_i,
    output soc_pkg::word_t        b_data_o,
    output logic                  b_ready_o
);

    // Scratchpad storage
    soc_pkg::word_t mem [`SOC_TCM_WORDS];

    // --------------------
    // Port A
    // --------------------
    always_ff @(posedge clk_i) begin
        if (a_en_i) begin
            a_data_o <= mem[a_index_i];
        end
    end

    // --------------------
    // Port B
    // --------------------
    // Read returns the old word on a write
    always_ff @(posedge clk_i) begin
        if (b_en_i) begin
            b_data_o <= mem[b_index_i];
            if (b_we_i) begin
                for (int k = 0; k < `SOC_DATA_WIDTH/8; k++) begin
                    if (b_byte_enable_i[k]) begin
                        mem[b_index_i][8*k +: 8] <= b_wdata_i[8*k +: 8];
                    end
                end
            end
        end
    end

    // One-cycle ready on each port
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            a_ready_o <= 1'b0;
            b_ready_o <= 1'b0;
        end else begin
            a_ready_o <= a_en_i;
            b_ready_o <= b_en_i;
        end
    end

endmodule

// File: hdl/mem_decoder.sv
`timescale 1ns/10ps
`include "soc_consts.svh"

module mem_decoder (
    input  logic                    clk_i,
    input  logic                    reset_i,
    // Instruction port from the core
    input  logic                    i_strobe_i,
    input  soc_pkg::addr_t          i_addr_i,
    output logic                    i_ready_o,
    output soc_pkg::word_t          i_code_o,
    // Data port from the core
    input  logic                    d_strobe_i,
    input  soc_pkg::addr_t          d_addr_i,
    input  logic                    d_rw_i,
    input  soc_pkg::byte_en_t       d_byte_enable_i,
    input  soc_pkg::word_t          d_wdata_i,
    output logic                    d_ready_o,
    output soc_pkg::word_t          d_rdata_o,
    // Uncached device port
    output logic                    dev_strobe_o,
    output soc_pkg::addr_t          dev_addr_o,
    output logic                    dev_rw_o,
    output soc_pkg::byte_en_t       dev_byte_enable_o,
    output soc_pkg::word_t          dev_wdata_o,
    input  logic                    dev_ready_i,
    input  soc_pkg::word_t          dev_rdata_i,
    // TCM side
    output logic                    tcm_i_en_o,
    output soc_pkg::tcm_index_t     tcm_i_index_o,
    output logic                    tcm_d_en_o,
    output logic                    tcm_d_we_o,
    output soc_pkg::tcm_index_t     tcm_d_index_o,
    output soc_pkg::byte_en_t       tcm_byte_enable_o,
    output soc_pkg::word_t          tcm_wdata_o,
    input  logic                    tcm_i_ready_i,
    input  soc_pkg::word_t          tcm_i_data_i,
    input  logic                    tcm_d_ready_i,
    input  soc_pkg::word_t          tcm_d_data_i,
    // CLINT side
    output logic                    clint_en_o,
    output logic                    clint_we_o,
    output soc_pkg::clint_index_t   clint_index_o,
    output soc_pkg::word_t          clint_wdata_o,
    input  logic                    clint_ready_i,
    input  soc_pkg::word_t          clint_rdata_i
);

    logic                i_in_tcm;
    logic                d_is_dev;
    soc_pkg::region_e    d_region;
    soc_pkg::region_e    region_q;
    logic                i_tcm_q;
    logic                i_unmapped_ready_q;
    logic                d_unmapped_ready_q;

    // --------------------
    // Address decode
    // --------------------
    // Code runs from the TCM only, anything else fetches zero
    assign i_in_tcm = (i_addr_i[`SOC_ADDR_WIDTH-1 -: 4] == `SOC_SEG_TCM);

    always_comb begin
        case (d_addr_i[`SOC_ADDR_WIDTH-1 -: 4])
            `SOC_SEG_TCM:    d_region = soc_pkg::region_tcm;
            `SOC_SEG_DEVICE: d_region = soc_pkg::region_device;
            `SOC_SEG_CLINT:  d_region = soc_pkg::region_clint;
            // DRAM and all other segments
            default:         d_region = soc_pkg::region_unmapped;
        endcase
    end

    assign d_is_dev = (d_region == soc_pkg::region_device);

    // --------------------
    // Request routing
    // --------------------
    assign tcm_i_en_o    = i_strobe_i && i_in_tcm;
    assign tcm_i_index_o = i_addr_i[`SOC_TCM_INDEX_WIDTH+1:2];

    assign tcm_d_en_o        = d_strobe_i && (d_region == soc_pkg::region_tcm);
    assign tcm_d_we_o        = tcm_d_en_o && d_rw_i;
    assign tcm_d_index_o     = d_addr_i[`SOC_TCM_INDEX_WIDTH+1:2];
    assign tcm_byte_enable_o = d_byte_enable_i;
    assign tcm_wdata_o       = d_wdata_i;

    // CLINT window is word addressed from bit 2
    assign clint_en_o    = d_strobe_i && (d_region == soc_pkg::region_clint);
    assign clint_we_o    = clint_en_o && d_rw_i;
    assign clint_index_o = d_addr_i[4:2];
    assign clint_wdata_o = d_wdata_i;

    // Device fields only show for device requests
    assign dev_strobe_o      = d_strobe_i && d_is_dev;
    assign dev_addr_o        = d_is_dev ? d_addr_i : '0;
    assign dev_rw_o          = d_rw_i && d_is_dev;
    assign dev_byte_enable_o = d_byte_enable_i;
    assign dev_wdata_o       = d_is_dev ? d_wdata_i : '0;

    // --------------------
    // Response select
    // --------------------
    // Region held from strobe to strobe, so slow devices still get their ready through
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            region_q           <= soc_pkg::region_unmapped;
            i_tcm_q            <= 1'b0;
            i_unmapped_ready_q <= 1'b0;
            d_unmapped_ready_q <= 1'b0;
        end else begin
            if (d_strobe_i) begin
                region_q <= d_region;
            end
            if (i_strobe_i) begin
                i_tcm_q <= i_in_tcm;
            end
            // Unmapped accesses complete in one cycle
            i_unmapped_ready_q <= i_strobe_i && !i_in_tcm;
            d_unmapped_ready_q <= d_strobe_i && (d_region == soc_pkg::region_unmapped);
        end
    end

    assign i_ready_o = i_tcm_q ? tcm_i_ready_i : i_unmapped_ready_q;
    assign i_code_o  = i_tcm_q ? tcm_i_data_i : '0;

    always_comb begin
        case (region_q)
            soc_pkg::region_tcm: begin
                d_ready_o = tcm_d_ready_i;
                d_rdata_o = tcm_d_data_i;
            end
            soc_pkg::region_device: begin
                d_ready_o = dev_ready_i;
                d_rdata_o = dev_rdata_i;
            end
            soc_pkg::region_clint: begin
                d_ready_o = clint_ready_i;
                d_rdata_o = clint_rdata_i;
            end
            default: begin
                // Unmapped reads return zero
                d_ready_o = d_unmapped_ready_q;
                d_rdata_o = '0;
            end
        endcase
    end

endmodule

// File: hdl/soc_pkg.sv
`include "soc_consts.svh"

package soc_pkg;

    // Byte address on both core ports
    typedef logic [`SOC_ADDR_WIDTH-1:0] addr_t;

    // One data word
    typedef logic [`SOC_DATA_WIDTH-1:0] word_t;

    // One enable per byte lane
    typedef logic [`SOC_DATA_WIDTH/8-1:0] byte_en_t;

    // Word index into the TCM
    typedef logic [`SOC_TCM_INDEX_WIDTH-1:0] tcm_index_t;

    // Word offset inside the CLINT window
    typedef logic [2:0] clint_index_t;

    // Target of a data request
    typedef enum logic [1:0] {
        region_tcm,
        region_device,
        region_clint,
        region_unmapped
    } region_e;

endpackage

// File: hdl/soc_consts.svh
`ifndef SOC_CONSTS_SVH
`define SOC_CONSTS_SVH

// --------------------
// Bus widths
// --------------------
`define SOC_ADDR_WIDTH 32
`define SOC_DATA_WIDTH 32

// --------------------
// Memory map segments
// --------------------
// Top four address bits select the segment
`define SOC_SEG_TCM    4'h0
`define SOC_SEG_DEVICE 4'hC
`define SOC_SEG_CLINT  4'hF

// TCM geometry, in 32-bit words
`define SOC_TCM_WORDS       1024
`define SOC_TCM_INDEX_WIDTH 10

// --------------------
// CLINT
// --------------------
// Clock cycles per mtime increment
`define SOC_CLINT_TICK_DIV 4

// Word offsets inside the CLINT window
`define SOC_CLINT_MSIP        3'd0
`define SOC_CLINT_MTIMECMP_LO 3'd2
`define SOC_CLINT_MTIMECMP_HI 3'd3
`define SOC_CLINT_MTIME_LO    3'd4
`define SOC_CLINT_MTIME_HI    3'd5

`endif
